/* src.f */
+incdir+verilog
verilog/ddr_cmd_pkg.sv
verilog/queue_ctrl_pkg.sv
verilog/queue_ctrl.sv
verilog/cmd_queue_store.sv
verilog/burst_merge_check.sv
verilog/cmd_queue_top.sv
dv/cmd_queue_monitor.sv
dv/cmd_queue_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# builds the command queue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* dv/tb_top.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module tb_top
    import ddr_cmd_pkg::*;
();

    localparam int RESET_CYCLES  = 10;
    localparam int STIM_CYCLES   = 3000;
    localparam int DRAIN_MARGIN  = 4 * `CMD_QUEUE_DEPTH + 20;
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + STIM_CYCLES + DRAIN_MARGIN;

    logic        ctl_clk;
    logic        ctl_reset_n;
    logic        req_valid;
    cmd_req_t    req;
    logic        fetch;
    logic        queue_full;
    logic        queue_empty;
    cmd_entry_t  look_ahead [0:`CMD_QUEUE_DEPTH-1];
    int          err_count;
    int          check_count;
    int          cycle_count = 0;
    logic [15:0] lfsr;
    logic        offered_full;

    cmd_queue_top dut0 (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .req_valid   (req_valid),
        .req         (req),
        .fetch       (fetch),
        .queue_full  (queue_full),
        .queue_empty (queue_empty),
        .look_ahead  (look_ahead)
    );

    cmd_queue_monitor mon0 (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .req_valid   (req_valid),
        .req         (req),
        .fetch       (fetch),
        .queue_full  (queue_full),
        .queue_empty (queue_empty),
        .look_ahead  (look_ahead),
        .err_count   (err_count),
        .check_count (check_count)
    );

    initial begin
        ctl_clk = 1'b0;
        forever begin
            #2 ctl_clk = ~ctl_clk;
        end
    end

    // fibonacci form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // mostly keeps the previous target so that mergeable pairs come up often
    task automatic new_request();
        logic [15:0] r;
        draw_bits(2, r);
        if (r[1:0] == 2'b00) begin
            draw_bits(5, r);
            req.op   = cmd_op_e'(r[0]);
            req.chip = r[1] ? 2'd1 : 2'd2;
            req.bank = r[2] ? 3'd5 : 3'd2;
            req.row  = r[3] ? 14'h1a3c : 14'h0c05;
            req.col[`CMD_COL_BITS-1:3] = r[4] ? 7'h15 : 7'h6a;
        end
        draw_bits(4, r);
        req.col[2:0] = {r[0], 2'b00};
        req.autopch  = r[1];
        req.size     = (r[3:2] == 2'b00) ? 2'd2 : 2'd1;
    endtask

    initial begin
        logic [15:0] r;
        lfsr         = 16'd92;
        ctl_reset_n  = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        fetch        = 1'b0;
        offered_full = 1'b0;
        repeat (RESET_CYCLES) @(posedge ctl_clk);
        @(negedge ctl_clk);
        ctl_reset_n = 1'b1;

        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(negedge ctl_clk);
            // a refused request stays on the bus unchanged
            if (!(req_valid && offered_full)) begin
                new_request();
                draw_bits(2, r);
                req_valid = (r[1:0] != 2'b00);
            end
            draw_bits(2, r);
            // phases that fill the queue alternate with phases that run it dry
            if ((c / 64) % 2 == 0) begin
                fetch = (r[1:0] == 2'b00);
            end else begin
                fetch = (r[1:0] != 2'b00);
            end
            offered_full = queue_full;
        end

        @(negedge ctl_clk);
        req_valid = 1'b0;
        fetch     = 1'b1;
        while (!queue_empty) begin
            @(negedge ctl_clk);
        end
        fetch = 1'b0;
        repeat (4) @(negedge ctl_clk);
        @(posedge ctl_clk);

        $display("errors: %0d, compare cycles: %0d", err_count, check_count);
        if (err_count == 0 && check_count > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge ctl_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

endmodule

/* dv/cmd_queue_checker.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module cmd_queue_checker
    import ddr_cmd_pkg::*;
(
    input logic        ctl_clk,
    input logic        ctl_reset_n,
    input logic        queue_full,
    input logic        queue_empty,
    input cmd_entry_t  look_ahead [0:`CMD_QUEUE_DEPTH-1]
);

    logic [`CMD_QUEUE_DEPTH-1:0] valids;

    always_comb begin
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            valids[i] = look_ahead[i].valid;
        end
    end

    // the flags follow the stored valid bits, so full and empty are never high together
    flags_match_valids: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (queue_full == (&valids)) && (queue_empty == (valids == '0)))
        else $error("queue_full or queue_empty disagrees with the look_ahead valid bits");

    // valid entries form a run of ones starting at the head
    valid_contiguous: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        (valids & (valids + `CMD_QUEUE_DEPTH'(1))) == '0)
        else $error("look_ahead valid bits are not contiguous from the head");

    empty_after_reset: assert property (@(posedge ctl_clk)
        $rose(ctl_reset_n) |-> (valids == '0))
        else $error("look_ahead holds valid entries right after reset");

endmodule

bind cmd_queue_top cmd_queue_checker checker0 (
    .ctl_clk     (ctl_clk),
    .ctl_reset_n (ctl_reset_n),
    .queue_full  (queue_full),
    .queue_empty (queue_empty),
    .look_ahead  (look_ahead)
);

/* dv/cmd_queue_monitor.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module cmd_queue_monitor
    import ddr_cmd_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        req_valid,
    input  cmd_req_t    req,
    input  logic        fetch,
    input  logic        queue_full,
    input  logic        queue_empty,
    input  cmd_entry_t  look_ahead [0:`CMD_QUEUE_DEPTH-1],
    output int          err_count,
    output int          check_count
);

    typedef cmd_entry_t [`CMD_QUEUE_DEPTH-1:0] queue_t;

    queue_t model_q;
    int     errs = 0;
    int     checks = 0;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic int occupancy(input queue_t q);
        int n;
        n = 0;
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            if (q[i].valid) begin
                n++;
            end
        end
        return n;
    endfunction

    // two single beats to the same row, older one on the lower half of the line
    function automatic logic pair_merges(input cmd_entry_t older, input cmd_req_t newer);
        return older.valid &&
               older.size == `CMD_SIZE_BITS'(1) && newer.size == `CMD_SIZE_BITS'(1) &&
               older.op == newer.op && older.chip == newer.chip &&
               older.bank == newer.bank && older.row == newer.row &&
               older.col[`CMD_COL_BITS-1:3] == newer.col[`CMD_COL_BITS-1:3] &&
               !older.col[2] && newer.col[2];
    endfunction

    function automatic queue_t model_step(input queue_t q, input logic valid,
                                          input cmd_req_t r, input logic fet);
        queue_t     nq;
        cmd_entry_t tail;
        int         n;
        logic       take;
        logic       pop;
        logic       merge;
        n     = occupancy(q);
        tail  = (n > 0) ? q[n-1] : '0;
        take  = valid && (n < `CMD_QUEUE_DEPTH);
        pop   = fet && (n > 0);
        // the head is never merged into, as it may leave in this cycle
        merge = take && (n >= 2) && pair_merges(tail, r);
        nq    = q;
        if (merge) begin
            nq[n-1].size = `CMD_SIZE_BITS'(2);
        end
        if (pop) begin
            for (int i = 0; i < `CMD_QUEUE_DEPTH - 1; i++) begin
                nq[i] = nq[i+1];
            end
            nq[`CMD_QUEUE_DEPTH-1] = '0;
            n = n - 1;
        end
        if (take && !merge) begin
            nq[n] = cmd_entry_t'({1'b1, r});
        end
        return nq;
    endfunction

    always @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            model_q <= '0;
        end else begin
            model_q <= model_step(model_q, req_valid, req, fetch);
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge ctl_clk) begin
        int   n;
        logic exp_full;
        logic exp_empty;
        n         = occupancy(model_q);
        exp_full  = (n == `CMD_QUEUE_DEPTH);
        exp_empty = (n == 0);
        checks++;
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            if (look_ahead[i] !== model_q[i]) begin
                $display("[ERROR] look_ahead[%0d] got %h, expected %h",
                         i, look_ahead[i], model_q[i]);
                errs++;
            end
        end
        if (queue_full !== exp_full) begin
            $display("[ERROR] queue_full got %h, expected %h", queue_full, exp_full);
            errs++;
        end
        if (queue_empty !== exp_empty) begin
            $display("[ERROR] queue_empty got %h, expected %h", queue_empty, exp_empty);
            errs++;
        end
    end

endmodule

/* verilog/cmd_queue_top.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module cmd_queue_top
    import ddr_cmd_pkg::*;
    import queue_ctrl_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        req_valid,
    input  cmd_req_t    req,
    input  logic        fetch,
    output logic        queue_full,
    output logic        queue_empty,
    output cmd_entry_t  look_ahead [0:`CMD_QUEUE_DEPTH-1]
);

    queue_action_e              action;
    logic [`CMD_COUNT_BITS-1:0] count;
    logic                       merge_ok;
    logic                       tail_not_head;
    cmd_entry_t                 tail_entry;

    queue_ctrl ctrl0 (
        .ctl_clk       (ctl_clk),
        .ctl_reset_n   (ctl_reset_n),
        .req_valid     (req_valid),
        .fetch         (fetch),
        .merge_ok      (merge_ok),
        .action        (action),
        .count         (count),
        .tail_not_head (tail_not_head),
        .queue_full    (queue_full),
        .queue_empty   (queue_empty)
    );

    cmd_queue_store store0 (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .action      (action),
        .count       (count),
        .req         (req),
        .look_ahead  (look_ahead),
        .tail_entry  (tail_entry)
    );

    burst_merge_check merge0 (
        .req           (req),
        .tail_entry    (tail_entry),
        .tail_not_head (tail_not_head),
        .merge_ok      (merge_ok)
    );

endmodule

/* verilog/burst_merge_check.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module burst_merge_check
    import ddr_cmd_pkg::*;
(
    input  cmd_req_t    req,
    input  cmd_entry_t  tail_entry,
    input  logic        tail_not_head,
    output logic        merge_ok
);

    logic same_target;
    logic same_line;
    logic single_beats;
    logic col_in_order;

    assign same_target = (tail_entry.op   == req.op)   &&
                         (tail_entry.chip == req.chip) &&
                         (tail_entry.bank == req.bank) &&
                         (tail_entry.row  == req.row);

    // two size 1 bursts share the upper column bits of one size 2 burst
    assign same_line = (tail_entry.col[`CMD_COL_BITS-1:3] == req.col[`CMD_COL_BITS-1:3]);

    assign single_beats = (tail_entry.size == `CMD_SIZE_BITS'(1)) &&
                          (req.size == `CMD_SIZE_BITS'(1));

    assign col_in_order = !tail_entry.col[2] && req.col[2];

    // the head may be fetched in this very cycle, so it is never merged into
    assign merge_ok = tail_not_head && tail_entry.valid && single_beats &&
                      same_target && same_line && col_in_order;

endmodule

/* verilog/cmd_queue_store.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module cmd_queue_store
    import ddr_cmd_pkg::*;
    import queue_ctrl_pkg::*;
(
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  queue_action_e               action,
    input  logic [`CMD_COUNT_BITS-1:0]  count,
    input  cmd_req_t                    req,
    output cmd_entry_t                  look_ahead [0:`CMD_QUEUE_DEPTH-1],
    output cmd_entry_t                  tail_entry
);

    cmd_entry_t                 entry     [0:`CMD_QUEUE_DEPTH-1];
    cmd_entry_t                 entry_nxt [0:`CMD_QUEUE_DEPTH-1];
    logic                       do_pop;
    logic                       do_push;
    logic                       do_merge;
    logic [`CMD_COUNT_BITS-1:0] push_slot;
    logic [`CMD_COUNT_BITS-1:0] merge_slot;
    logic [`CMD_COUNT_BITS-1:0] tail_slot;

    assign do_pop   = (action == Q_POP) || (action == Q_PUSH_POP) ||
                      (action == Q_MERGE_POP);
    assign do_push  = (action == Q_PUSH) || (action == Q_PUSH_POP);
    assign do_merge = (action == Q_MERGE) || (action == Q_MERGE_POP);

    assign tail_slot = count - `CMD_COUNT_BITS'(1);

    // slots are taken after the shift, so both move down by one on a pop
    assign push_slot  = do_pop ? count - `CMD_COUNT_BITS'(1) : count;
    assign merge_slot = do_pop ? count - `CMD_COUNT_BITS'(2) : tail_slot;

    always_comb begin
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            if (!do_pop) begin
                entry_nxt[i] = entry[i];
            end else if (i < `CMD_QUEUE_DEPTH - 1) begin
                entry_nxt[i] = entry[i+1];
            end else begin
                entry_nxt[i] = '0;
            end
        end
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            if (do_push && push_slot == `CMD_COUNT_BITS'(i)) begin
                entry_nxt[i] = cmd_entry_t'({1'b1, req});
            end
            // the older request keeps its column, only the burst grows
            if (do_merge && merge_slot == `CMD_COUNT_BITS'(i)) begin
                entry_nxt[i].size = `CMD_SIZE_BITS'(2);
            end
        end
    end

    // invalid entries stay all zero, which keeps look_ahead fully defined
    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
                entry[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
                entry[i] <= entry_nxt[i];
            end
        end
    end

    always_comb begin
        tail_entry = '0;
        for (int i = 0; i < `CMD_QUEUE_DEPTH; i++) begin
            if (count != '0 && tail_slot == `CMD_COUNT_BITS'(i)) begin
                tail_entry = entry[i];
            end
        end
    end

    assign look_ahead = entry;

endmodule

/* verilog/queue_ctrl.sv */
`timescale 1ns/10ps

`include "cmd_queue_defs.svh"

module queue_ctrl
    import queue_ctrl_pkg::*;
(
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        req_valid,
    input  logic                        fetch,
    input  logic                        merge_ok,
    output queue_action_e               action,
    output logic [`CMD_COUNT_BITS-1:0]  count,
    output logic                        tail_not_head,
    output logic                        queue_full,
    output logic                        queue_empty
);

    logic accept;
    logic pop;

    assign queue_full    = (count == `CMD_COUNT_BITS'(`CMD_QUEUE_DEPTH));
    assign queue_empty   = (count == '0);
    assign tail_not_head = (count >= `CMD_COUNT_BITS'(2));

    // a fetch in the same cycle never frees a slot for the request
    assign accept = req_valid && !queue_full;
    assign pop    = fetch && !queue_empty;

    always_comb begin
        if (accept && merge_ok) begin
            action = pop ? Q_MERGE_POP : Q_MERGE;
        end else if (accept) begin
            action = pop ? Q_PUSH_POP : Q_PUSH;
        end else begin
            action = pop ? Q_POP : Q_HOLD;
        end
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n) begin
        if (!ctl_reset_n) begin
            count <= '0;
        end else begin
            case (action)
                Q_PUSH: begin
                    count <= count + `CMD_COUNT_BITS'(1);
                end
                Q_POP, Q_MERGE_POP: begin
                    count <= count - `CMD_COUNT_BITS'(1);
                end
                default: begin
                    // push with pop and a plain merge leave occupancy alone
                    count <= count;
                end
            endcase
        end
    end

endmodule

/* verilog/queue_ctrl_pkg.sv */
package queue_ctrl_pkg;

    // what the entry storage does at the next clock edge
    typedef enum logic [2:0] {
        Q_HOLD      = 3'd0,
        Q_PUSH      = 3'd1,
        Q_POP       = 3'd2,
        Q_PUSH_POP  = 3'd3,
        Q_MERGE     = 3'd4,
        Q_MERGE_POP = 3'd5
    } queue_action_e;

endpackage

/* verilog/ddr_cmd_pkg.sv */
`include "cmd_queue_defs.svh"

package ddr_cmd_pkg;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_op_e;

    // request as offered by the local side
    typedef struct packed {
        cmd_op_e                    op;
        logic                       autopch;
        logic [`CMD_SIZE_BITS-1:0]  size;
        logic [`CMD_CHIP_BITS-1:0]  chip;
        logic [`CMD_BANK_BITS-1:0]  bank;
        logic [`CMD_ROW_BITS-1:0]   row;
        logic [`CMD_COL_BITS-1:0]   col;
    } cmd_req_t;

    // same layout as cmd_req_t below the valid bit, so a request can be cast
    // straight into an entry
    typedef struct packed {
        logic                       valid;
        cmd_op_e                    op;
        logic                       autopch;
        logic [`CMD_SIZE_BITS-1:0]  size;
        logic [`CMD_CHIP_BITS-1:0]  chip;
        logic [`CMD_BANK_BITS-1:0]  bank;
        logic [`CMD_ROW_BITS-1:0]   row;
        logic [`CMD_COL_BITS-1:0]   col;
    } cmd_entry_t;

endpackage

/* verilog/cmd_queue_defs.svh */
`ifndef CMD_QUEUE_DEFS_SVH
`define CMD_QUEUE_DEFS_SVH

// address field widths of a local request
`define CMD_CHIP_BITS 2
`define CMD_BANK_BITS 3
`define CMD_ROW_BITS 14
`define CMD_COL_BITS 10

// burst count, 1 or 2 beats of the local interface
`define CMD_SIZE_BITS 2

// number of queue entries, all of them visible to the scheduler
`define CMD_QUEUE_DEPTH 4

// occupancy count must hold 0 to CMD_QUEUE_DEPTH
`define CMD_COUNT_BITS 3

`endif
